// File: hw/periph_map_pkg.sv
// Peripheral address map: bus widths, slot geometry, slot names and access-size codes
package periph_map_pkg;

    // Bus widths seen by the core
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;

    // Address bit 10 selects the byte-access group
    localparam int GROUP_BIT = 10;

    // Full slots are 64 bytes, byte slots are 16 bytes
    localparam int USER_OFS_W = 6;
    localparam int BYTE_OFS_W = 4;

    // Each group has sixteen slots
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

    // Named full-interface slots, the others are unpopulated
    typedef enum logic [SLOT_IDX_W-1:0] {
        SLOT_RESERVED = 4'd0,
        SLOT_GPIO     = 4'd1,
        SLOT_UART     = 4'd2
    } slot_e;

    // Size code on the read and write strobes
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_e;

endpackage

// File: hw/gpio_pkg.sv
// GPIO register offsets, output function-select type and select reset values
package gpio_pkg;

    // Output pin count and the width of a pin index
    localparam int PIN_COUNT = 8;
    localparam int PIN_IDX_W = $clog2(PIN_COUNT);

    // Pins 0 and 1 belong to the UART after reset
    localparam int UART_PIN_COUNT = 2;

    // Register offsets inside the GPIO slot
    localparam logic [periph_map_pkg::USER_OFS_W-1:0] REG_OUT  = 6'h00;
    localparam logic [periph_map_pkg::USER_OFS_W-1:0] REG_IN   = 6'h04;
    // Select for pin p sits at SEL_BASE + 4*p
    localparam logic [periph_map_pkg::USER_OFS_W-1:0] SEL_BASE = 6'h20;

    // Output function select, byte_grp set means a byte-group slot
    typedef struct packed {
        logic                                  byte_grp;
        logic [periph_map_pkg::SLOT_IDX_W-1:0] slot;
    } func_sel_t;

    localparam func_sel_t SEL_RESET_GPIO = '{
        byte_grp: 1'b0,
        slot:     periph_map_pkg::SLOT_GPIO
    };
    localparam func_sel_t SEL_RESET_UART = '{
        byte_grp: 1'b0,
        slot:     periph_map_pkg::SLOT_UART
    };

endpackage

// File: hw/periph_bus_if.sv
// Register access interface between the address decoder and one selected slot
interface periph_bus_if #(
    parameter int OFS_W  = 6,
    parameter int DATA_W = 32
);

    // Register offset inside the slot
    logic [OFS_W-1:0]  offset;
    // Write data, low bits carry byte and half writes
    logic [DATA_W-1:0] wdata;
    // Write strobe, already qualified by the slot select
    logic              wr;
    // Read data, combinational from offset
    logic [DATA_W-1:0] rdata;

    modport host (
        output offset,
        output wdata,
        output wr,
        input  rdata
    );

    modport device (
        input  offset,
        input  wdata,
        input  wr,
        output rdata
    );

endinterface

// File: hw/periph_decode.sv
// Address decoder with GPIO write gating and slot read-data and ready mux
module periph_decode (
    input  logic [periph_map_pkg::ADDR_W-1:0] i_addr,
    input  logic [periph_map_pkg::DATA_W-1:0] i_data,
    input  periph_map_pkg::access_e           i_write_n,
    periph_bus_if.host                        bus,
    output logic [periph_map_pkg::DATA_W-1:0] o_slot_data,
    output logic                              o_slot_ready
);

    import periph_map_pkg::*;

    logic                  byte_grp;
    logic [SLOT_IDX_W-1:0] slot_idx;
    slot_e                 slot;
    logic                  gpio_sel;
    logic                  write_req;

    // Group bit picks which address field holds the slot index
    assign byte_grp = i_addr[GROUP_BIT];
    assign slot_idx = byte_grp ? i_addr[BYTE_OFS_W +: SLOT_IDX_W]
                               : i_addr[USER_OFS_W +: SLOT_IDX_W];
    assign slot     = slot_e'(slot_idx);

    assign gpio_sel  = !byte_grp && (slot == SLOT_GPIO);
    assign write_req = (i_write_n != ACC_NONE);

    // Only GPIO is populated, so only it sees the write strobe
    assign bus.offset = i_addr[USER_OFS_W-1:0];
    assign bus.wdata  = i_data;
    assign bus.wr     = gpio_sel && write_req;

    always_comb begin
        // Unpopulated slots read zero and complete at once
        o_slot_data  = '0;
        o_slot_ready = 1'b1;
        if (!byte_grp) begin
            case (slot)
                SLOT_GPIO: begin
                    o_slot_data = bus.rdata;
                end
                SLOT_RESERVED: begin
                    // Reads here never complete
                    o_slot_ready = 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/read_return.sv
// Registered read return with hold until read-complete and ready generation
module read_return (
    input  logic                              clk,
    input  logic                              rst_n,
    input  periph_map_pkg::access_e           i_write_n,
    input  periph_map_pkg::access_e           i_read_n,
    input  logic [periph_map_pkg::DATA_W-1:0] i_slot_data,
    input  logic                              i_slot_ready,
    input  logic                              i_read_complete,
    output logic [periph_map_pkg::DATA_W-1:0] o_data,
    output logic                              o_data_ready
);

    import periph_map_pkg::*;

    logic              read_req;
    logic              capture;
    logic              hold;
    logic              ready_r;
    logic [DATA_W-1:0] data_r;

    assign read_req = (i_read_n != ACC_NONE);
    // A new value is only taken once the previous one was consumed
    assign capture  = !hold && read_req && i_slot_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            // Ready lags the request by one cycle to match the data register
            ready_r <= read_req && i_slot_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_slot_data;
        end
    end

    assign o_data       = data_r;
    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_r || (i_write_n != ACC_NONE);

endmodule

// File: hw/gpio_ctrl.sv
// GPIO slot with output register, per-pin function selects, readback and output-pin router
module gpio_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [gpio_pkg::PIN_COUNT-1:0] i_ui_in,
    periph_bus_if.device                   bus,
    output logic [gpio_pkg::PIN_COUNT-1:0] o_uo_out
);

    import periph_map_pkg::*;
    import gpio_pkg::*;

    localparam int SEL_W = $bits(func_sel_t);

    logic [PIN_COUNT-1:0]  out_r;
    func_sel_t             sel_r [PIN_COUNT];

    logic                  out_hit;
    logic                  in_hit;
    logic                  sel_hit;
    logic [USER_OFS_W-1:0] sel_rel;
    logic [PIN_IDX_W-1:0]  sel_idx;

    // Offset decode
    assign out_hit = (bus.offset == REG_OUT);
    assign in_hit  = (bus.offset == REG_IN);
    assign sel_rel = bus.offset - SEL_BASE;
    // The select block fills the upper half of the slot
    assign sel_hit = (bus.offset >= SEL_BASE) && (sel_rel[1:0] == 2'b00);
    assign sel_idx = sel_rel[2 +: PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_r <= '0;
        end else if (bus.wr && out_hit) begin
            out_r <= bus.wdata[PIN_COUNT-1:0];
        end
    end

    // The first pins default to the UART slot
    always_ff @(posedge clk) begin
        for (int p = 0; p < PIN_COUNT; p++) begin
            if (!rst_n) begin
                sel_r[p] <= (p < UART_PIN_COUNT) ? SEL_RESET_UART : SEL_RESET_GPIO;
            end else if (bus.wr && sel_hit && (sel_idx == p)) begin
                sel_r[p] <= func_sel_t'(bus.wdata[SEL_W-1:0]);
            end
        end
    end

    // Readback is zero-extended to the bus width
    always_comb begin
        bus.rdata = '0;
        if (out_hit) begin
            bus.rdata[PIN_COUNT-1:0] = out_r;
        end else if (in_hit) begin
            bus.rdata[PIN_COUNT-1:0] = i_ui_in;
        end else if (sel_hit) begin
            bus.rdata[SEL_W-1:0] = sel_r[sel_idx];
        end
    end

    // Output router
    // Any source other than full slot GPIO drives 0
    always_comb begin
        o_uo_out = '0;
        for (int p = 0; p < PIN_COUNT; p++) begin
            if (!sel_r[p].byte_grp && (sel_r[p].slot == SLOT_GPIO)) begin
                o_uo_out[p] = out_r[p];
            end
        end
    end

endmodule

// File: hw/tqv_periph_top.sv
// Peripheral wrapper top level: decoder, read return and GPIO slot on plain ports
module tqv_periph_top (
    input  logic                              clk,
    input  logic                              rst_n,

    // Pin ports
    input  logic [7:0]                        i_ui_in,
    output logic [7:0]                        o_uo_out,

    // Core bus
    input  logic [periph_map_pkg::ADDR_W-1:0] i_addr,
    input  logic [periph_map_pkg::DATA_W-1:0] i_data,
    input  periph_map_pkg::access_e           i_write_n,
    input  periph_map_pkg::access_e           i_read_n,
    output logic [periph_map_pkg::DATA_W-1:0] o_data,
    output logic                              o_data_ready,
    input  logic                              i_read_complete
);

    import periph_map_pkg::*;

    logic [DATA_W-1:0] slot_data;
    logic              slot_ready;

    periph_bus_if #(
        .OFS_W  (USER_OFS_W),
        .DATA_W (DATA_W)
    ) gpio_bus ();

    periph_decode u_decode (
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_write_n    (i_write_n),
        .bus          (gpio_bus.host),
        .o_slot_data  (slot_data),
        .o_slot_ready (slot_ready)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_slot_data     (slot_data),
        .i_slot_ready    (slot_ready),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_ui_in  (i_ui_in),
        .bus      (gpio_bus.device),
        .o_uo_out (o_uo_out)
    );

endmodule

// File: bench/tqv_periph_tb.sv
// Testbench for tqv_periph_top: clock, reset, stimulus table, reference model, checker, timeout
module tqv_periph_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import periph_map_pkg::*;
    import gpio_pkg::*;

    localparam int CLK_PERIOD = 8;
    // Roughly four times the cycles the stimulus table needs
    localparam int TIMEOUT_CYCLES = 400;
    localparam logic [ADDR_W-1:0] GPIO_BASE = 11'h040;
    localparam logic [ADDR_W-1:0] BYTE_BASE = 11'h400;

    typedef enum {OP_WRITE, OP_READ, OP_PINS} op_e;

    typedef struct {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        access_e           size;
        logic [7:0]        ui;
        logic [DATA_W-1:0] exp;
        logic              keep;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic [7:0]        i_ui_in;
    logic [7:0]        o_uo_out;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data;
    access_e           i_write_n;
    access_e           i_read_n;
    logic [DATA_W-1:0] o_data;
    logic              o_data_ready;
    logic              i_read_complete;

    entry_t            stim_q[$];
    logic [31:0]       rng_state = 32'hb2dc_97a0;
    // Reference model of the GPIO slot and the read hold
    logic [7:0]        model_out;
    func_sel_t         model_sel [PIN_COUNT];
    logic [DATA_W-1:0] model_data;
    logic              model_holding;
    logic [7:0]        cur_ui;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    tqv_periph_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .o_uo_out        (o_uo_out),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .i_read_complete (i_read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Pins follow the output register only when routed to full slot GPIO
    function automatic logic [PIN_COUNT-1:0] expected_pins();
        logic [PIN_COUNT-1:0] pins;
        pins = '0;
        for (int p = 0; p < PIN_COUNT; p++) begin
            if (model_sel[p] == SEL_RESET_GPIO) begin
                pins[p] = model_out[p];
            end
        end
        return pins;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_entry(input op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input access_e size,
                             input logic [DATA_W-1:0] exp, input logic keep);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.size = size;
        e.ui   = cur_ui;
        e.exp  = exp;
        e.keep = keep;
        stim_q.push_back(e);
    endtask

    task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input access_e size);
        logic [USER_OFS_W-1:0] ofs;
        ofs = addr[USER_OFS_W-1:0];
        if (!addr[GROUP_BIT] && (addr[USER_OFS_W +: 4] == SLOT_GPIO)) begin
            if (ofs == REG_OUT) begin
                model_out = data[7:0];
            end else if ((ofs >= SEL_BASE) && (ofs[1:0] == 2'b00)) begin
                model_sel[(ofs - SEL_BASE) >> 2] = func_sel_t'(data[4:0]);
            end
        end
        add_entry(OP_WRITE, addr, data, size, '0, 1'b0);
    endtask

    // A read only captures when no earlier value is still held
    task automatic add_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] value,
                            input logic keep);
        if (!model_holding) begin
            model_data = value;
        end
        model_holding = keep;
        add_entry(OP_READ, addr, '0, ACC_WORD, model_data, keep);
    endtask

    task automatic add_pins();
        add_entry(OP_PINS, '0, '0, ACC_NONE, 32'(expected_pins()), 1'b0);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        func_sel_t   sel_byte;
        sel_byte      = '{byte_grp: 1'b1, slot: SLOT_GPIO};
        model_out     = '0;
        model_data    = '0;
        model_holding = 1'b0;
        cur_ui        = '0;
        for (int p = 0; p < PIN_COUNT; p++) begin
            model_sel[p] = (p < 2) ? SEL_RESET_UART : SEL_RESET_GPIO;
        end
        // Reset routing
        add_pins();
        add_read(GPIO_BASE + SEL_BASE, 32'(SEL_RESET_UART), 1'b0);
        add_read(GPIO_BASE + SEL_BASE + 11'd20, 32'(SEL_RESET_GPIO), 1'b0);
        // Output register, pins 0 and 1 still on the UART slot
        rnd = next_random();
        add_write(GPIO_BASE + REG_OUT, rnd, ACC_BYTE);
        add_read(GPIO_BASE + REG_OUT, 32'(model_out), 1'b0);
        add_pins();
        rnd = next_random();
        cur_ui = rnd[15:8];
        add_read(GPIO_BASE + REG_IN, 32'(cur_ui), 1'b0);
        // Route pins 0 and 1 to GPIO, then pin 7 to a byte slot
        rnd = next_random();
        add_write(GPIO_BASE + SEL_BASE, {rnd[31:5], SEL_RESET_GPIO}, ACC_WORD);
        add_write(GPIO_BASE + SEL_BASE + 11'd4, {rnd[31:5], SEL_RESET_GPIO}, ACC_WORD);
        add_pins();
        add_write(GPIO_BASE + SEL_BASE + 11'd28, 32'(sel_byte), ACC_BYTE);
        add_read(GPIO_BASE + SEL_BASE + 11'd28, 32'(sel_byte), 1'b0);
        rnd = next_random();
        add_write(GPIO_BASE + REG_OUT, rnd | 32'h83, ACC_BYTE);
        add_pins();
        // Unpopulated full and byte slots
        add_read(11'h140, '0, 1'b0);
        add_read(BYTE_BASE + 11'h030, '0, 1'b0);
        add_write(11'h0c0, next_random(), ACC_WORD);
        add_write(11'h080, next_random(), ACC_WORD);
        add_write(BYTE_BASE + REG_OUT, next_random(), ACC_BYTE);
        add_write(BYTE_BASE + SEL_BASE, '0, ACC_BYTE);
        add_read(GPIO_BASE + REG_OUT, 32'(model_out), 1'b0);
        add_read(GPIO_BASE + SEL_BASE, 32'(model_sel[0]), 1'b0);
        add_pins();
        // Read hold, the second read keeps the first value
        rnd = next_random();
        cur_ui = rnd[23:16];
        add_read(GPIO_BASE + REG_IN, 32'(cur_ui), 1'b1);
        cur_ui = ~cur_ui;
        add_read(GPIO_BASE + REG_IN, 32'(cur_ui), 1'b0);
        add_read(GPIO_BASE + REG_IN, 32'(cur_ui), 1'b0);
    endtask

    task automatic apply_entry(input entry_t e, input int idx);
        @(posedge clk);
        #1;
        i_ui_in = e.ui;
        case (e.op)
            OP_WRITE: begin
                i_addr    = e.addr;
                i_data    = e.data;
                i_write_n = e.size;
                #3;
                check_value(32'(o_data_ready), 32'd1, $sformatf("entry %0d write ready", idx));
                @(posedge clk);
                #1;
                i_write_n = ACC_NONE;
            end
            OP_READ: begin
                i_addr   = e.addr;
                i_read_n = e.size;
                @(posedge clk);
                #1;
                i_read_n = ACC_NONE;
                #3;
                check_value(32'(o_data_ready), 32'd1, $sformatf("entry %0d read ready", idx));
                check_value(o_data, e.exp, $sformatf("entry %0d read data", idx));
                if (!e.keep) begin
                    @(posedge clk);
                    #1;
                    i_read_complete = 1'b1;
                    @(posedge clk);
                    #1;
                    i_read_complete = 1'b0;
                end
            end
            default: begin
                #3;
                check_value(32'(o_uo_out), e.exp, $sformatf("entry %0d output pins", idx));
            end
        endcase
    endtask

    initial begin
        rst_n           = 1'b0;
        i_ui_in         = '0;
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = ACC_NONE;
        i_read_n        = ACC_NONE;
        i_read_complete = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #3;
        check_value(32'(o_uo_out), 32'd0, "o_uo_out after reset");
        check_value(32'(o_data_ready), 32'd0, "o_data_ready after reset");
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i], i);
        end
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tqv_periph_top.f
hw/periph_map_pkg.sv
hw/gpio_pkg.sv
hw/periph_bus_if.sv
hw/periph_decode.sv
hw/read_return.sv
hw/gpio_ctrl.sv
hw/tqv_periph_top.sv
bench/tqv_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tqv_periph_tb \
    -f tqv_periph_top.f -Mdir obj_dir \
    && ./obj_dir/Vtqv_periph_tb | tee /dev/stderr | grep -q "No errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
